/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// -------------------------------------------------------------------------
	// Widths and flag word layout
	// -------------------------------------------------------------------------
	localparam int xlen = 16;     // Data and address width
	localparam int nreg = 16;     // Register count, r0 reads zero
	localparam int reg_sel_w = 4;

	localparam int flag_z = 2;    // Zero
	localparam int flag_v = 1;    // Overflow
	localparam int flag_n = 0;    // Negative

	// -------------------------------------------------------------------------
	// Encodings
	// -------------------------------------------------------------------------
	typedef enum logic [3:0] {
		op_add = 4'h0,
		op_sub = 4'h1,
		op_xor = 4'h2,
		op_sll = 4'h4,
		op_sra = 4'h5,
		op_ror = 4'h6,
		op_lw  = 4'h8,
		op_sw  = 4'h9,
		op_lhb = 4'ha,
		op_llb = 4'hb,
		op_b   = 4'hc,
		op_hlt = 4'hf
	} opcode_e;

	typedef enum logic [2:0] {
		cond_ne = 3'd0,
		cond_eq = 3'd1,
		cond_gt = 3'd2,
		cond_lt = 3'd3,
		cond_ge = 3'd4,
		cond_le = 3'd5,
		cond_ov = 3'd6,
		cond_al = 3'd7   // Ignores flags
	} cond_e;

	// Operand source in EX
	typedef enum logic [1:0] {
		fwd_rf  = 2'd0,
		fwd_mem = 2'd1,
		fwd_wb  = 2'd2
	} fwd_e;

	// Register form, rt is also the imm4 of shifts and memory offsets
	typedef struct packed {
		opcode_e opcode;
		logic [reg_sel_w-1:0] rd;
		logic [reg_sel_w-1:0] rs;
		logic [reg_sel_w-1:0] rt;
	} instr_r_t;

	typedef struct packed {
		cond_e cond;
		logic [8:0] offset;   // Signed, in words
	} br_field_t;

	typedef struct packed {
		logic [reg_sel_w-1:0] rd;
		logic [7:0] imm8;
	} byte_field_t;

	// Low twelve bits of B versus LHB/LLB
	typedef union packed {
		br_field_t br;
		byte_field_t bt;
	} bb_body_t;

	typedef struct packed {
		opcode_e opcode;
		bb_body_t body;
	} instr_b_t;

	typedef union packed {
		instr_r_t r;
		instr_b_t b;
	} instr_t;

endpackage

`default_nettype wire

/* hw/dmem_if.sv */
`default_nettype none

// MEM stage to data port unit
interface dmem_if;
	logic en;                           // Load or store pending
	logic wr;                           // Store when set
	logic [cpu_pkg::xlen-1:0] addr;
	logic [cpu_pkg::xlen-1:0] wdata;
	logic [cpu_pkg::xlen-1:0] rdata;    // Meaningful with done
	logic done;                         // Access completes this cycle

	modport stage (
		output en, wr, addr, wdata,
		input rdata, done
	);

	modport port (
		input en, wr, addr, wdata,
		output rdata, done
	);

endinterface

`default_nettype wire

/* hw/regfile.sv */
`default_nettype none

module regfile (
	input  logic clk,
	input  logic rst_n,
	input  logic [cpu_pkg::reg_sel_w-1:0] rsel1,
	input  logic [cpu_pkg::reg_sel_w-1:0] rsel2,
	input  logic [cpu_pkg::reg_sel_w-1:0] wsel,
	input  logic wen,
	input  logic [cpu_pkg::xlen-1:0] wdata,
	output logic [cpu_pkg::xlen-1:0] rdata1,
	output logic [cpu_pkg::xlen-1:0] rdata2
);

	logic [cpu_pkg::xlen-1:0] regs [cpu_pkg::nreg];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::nreg; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && wsel != '0) begin   // r0 never written
			regs[wsel] <= wdata;
		end
	end

	// Same-cycle WB write shows up on the read side
	assign rdata1 = (rsel1 == '0) ? '0 :
		(wen && wsel == rsel1) ? wdata : regs[rsel1];
	assign rdata2 = (rsel2 == '0) ? '0 :
		(wen && wsel == rsel2) ? wdata : regs[rsel2];

endmodule

`default_nettype wire

/* hw/alu.sv */
`default_nettype none

module alu (
	input  logic [cpu_pkg::xlen-1:0] a,
	input  logic [cpu_pkg::xlen-1:0] b,          // Register or zero-extended imm4
	input  cpu_pkg::opcode_e op,
	output logic [cpu_pkg::xlen-1:0] result,
	output logic [2:0] flags,
	output logic [2:0] flag_wen
);

	logic [cpu_pkg::xlen:0] sum_ext;        // Sign-extended by one bit
	logic ovf;
	logic [2*cpu_pkg::xlen-1:0] rot;        // Doubled word for rotate

	assign sum_ext = (op == cpu_pkg::op_sub) ?
		{a[cpu_pkg::xlen-1], a} - {b[cpu_pkg::xlen-1], b} :
		{a[cpu_pkg::xlen-1], a} + {b[cpu_pkg::xlen-1], b};
	assign ovf = sum_ext[cpu_pkg::xlen] ^ sum_ext[cpu_pkg::xlen-1];
	assign rot = {a, a} >> b[3:0];

	always_comb begin
		result = '0;
		flag_wen = '0;
		case (op)
			cpu_pkg::op_add, cpu_pkg::op_sub: begin
				if (!ovf)
					result = sum_ext[cpu_pkg::xlen-1:0];
				else if (sum_ext[cpu_pkg::xlen])
					result = {1'b1, {(cpu_pkg::xlen-1){1'b0}}};   // Clamp to most negative
				else
					result = {1'b0, {(cpu_pkg::xlen-1){1'b1}}};   // Clamp to most positive
				flag_wen = '1;
			end
			cpu_pkg::op_xor: begin
				result = a ^ b;
				flag_wen[cpu_pkg::flag_z] = 1'b1;
			end
			cpu_pkg::op_sll: begin
				result = a << b[3:0];
				flag_wen[cpu_pkg::flag_z] = 1'b1;
			end
			cpu_pkg::op_sra: begin
				result = $signed(a) >>> b[3:0];
				flag_wen[cpu_pkg::flag_z] = 1'b1;
			end
			cpu_pkg::op_ror: begin
				result = rot[cpu_pkg::xlen-1:0];
				flag_wen[cpu_pkg::flag_z] = 1'b1;
			end
			default: result = '0;   // Memory, byte and branch ops leave flags alone
		endcase
	end

	// V only means something for ADD and SUB, flag_wen keeps it out otherwise
	always_comb begin
		flags[cpu_pkg::flag_z] = (result == '0);
		flags[cpu_pkg::flag_v] = ovf;
		flags[cpu_pkg::flag_n] = result[cpu_pkg::xlen-1];
	end

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
`default_nettype none

module hazard_unit (
	input  logic [cpu_pkg::reg_sel_w-1:0] ex_rs,
	input  logic [cpu_pkg::reg_sel_w-1:0] ex_rt,
	input  logic [cpu_pkg::reg_sel_w-1:0] mem_rd,
	input  logic [cpu_pkg::reg_sel_w-1:0] wb_rd,
	input  logic [cpu_pkg::reg_sel_w-1:0] id_rs,
	input  logic [cpu_pkg::reg_sel_w-1:0] id_rt,
	input  logic [cpu_pkg::reg_sel_w-1:0] ex_rd,
	input  logic mem_regwrite,
	input  logic wb_regwrite,
	input  logic ex_memread,     // Valid LW sitting in EX
	input  logic branch_taken,
	output cpu_pkg::fwd_e fwd_a,
	output cpu_pkg::fwd_e fwd_b,
	output logic load_stall,
	output logic flush
);

	// MEM holds the younger result so it wins over WB
	function automatic cpu_pkg::fwd_e pick_src(
		input logic [cpu_pkg::reg_sel_w-1:0] src,
		input logic mem_we,
		input logic [cpu_pkg::reg_sel_w-1:0] mem_dst,
		input logic wb_we,
		input logic [cpu_pkg::reg_sel_w-1:0] wb_dst
	);
		if (src == '0)
			return cpu_pkg::fwd_rf;   // r0 is constant
		if (mem_we && mem_dst == src)
			return cpu_pkg::fwd_mem;
		if (wb_we && wb_dst == src)
			return cpu_pkg::fwd_wb;
		return cpu_pkg::fwd_rf;
	endfunction

	assign fwd_a = pick_src(ex_rs, mem_regwrite, mem_rd, wb_regwrite, wb_rd);
	assign fwd_b = pick_src(ex_rt, mem_regwrite, mem_rd, wb_regwrite, wb_rd);

	// Load data is not ready until MEM, one bubble covers it
	assign load_stall = ex_memread && ex_rd != '0 && (ex_rd == id_rs || ex_rd == id_rt);
	assign flush = branch_taken;   // Kills IF/ID and ID/EX

endmodule

`default_nettype wire

/* hw/dmem_port.sv */
`default_nettype none

module dmem_port (
	input  logic clk,
	input  logic rst_n,
	dmem_if.port mem,
	output logic dmem_en,
	output logic dmem_wr,
	output logic [cpu_pkg::xlen-1:0] dmem_addr,
	output logic [cpu_pkg::xlen-1:0] dmem_wdata,
	input  logic [cpu_pkg::xlen-1:0] dmem_rdata,
	input  logic dmem_valid,
	output logic mem_stall
);

	logic done_q;   // An access ended last cycle

	// Request stays on the port until valid, then drops for one cycle
	// so a request still presented is never taken as a second access
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			done_q <= 1'b0;
		else
			done_q <= mem.done;
	end

	assign dmem_en = mem.en && !done_q;
	assign dmem_wr = dmem_en && mem.wr;
	assign dmem_addr = mem.addr;     // Held by EX/MEM while stalled
	assign dmem_wdata = mem.wdata;

	assign mem.rdata = dmem_rdata;
	assign mem.done = dmem_en && dmem_valid;   // Combinational, same cycle as valid

	// Whole pipeline waits on the outstanding access
	assign mem_stall = mem.en && !mem.done;

endmodule

`default_nettype wire

/* hw/cpu_core.sv */
`default_nettype none

module cpu_core (
	input  logic clk,
	input  logic rst_n,
	input  logic [cpu_pkg::xlen-1:0] imem_rdata,   // Word at pc, same cycle
	output logic [cpu_pkg::xlen-1:0] pc,
	dmem_if.stage mem,
	input  logic mem_stall,                         // Data port busy, freeze all
	output logic hlt
);

	// IF/ID
	cpu_pkg::instr_t id_ins;
	logic [cpu_pkg::xlen-1:0] id_pc2;
	logic id_valid;
	logic fetch_halt;                      // HLT went past ID, fetch stopped

	// ID
	cpu_pkg::opcode_e id_op;
	logic [cpu_pkg::reg_sel_w-1:0] id_rs_sel;
	logic [cpu_pkg::reg_sel_w-1:0] id_rt_sel;
	logic [cpu_pkg::xlen-1:0] id_a;
	logic [cpu_pkg::xlen-1:0] id_b;
	logic id_hlt;

	// ID/EX and EX
	cpu_pkg::instr_t ex_ins;
	logic ex_valid;
	logic [cpu_pkg::xlen-1:0] ex_pc2;
	logic [cpu_pkg::xlen-1:0] ex_a;
	logic [cpu_pkg::xlen-1:0] ex_b;
	logic [cpu_pkg::reg_sel_w-1:0] ex_rs;
	logic [cpu_pkg::reg_sel_w-1:0] ex_rt;
	cpu_pkg::opcode_e ex_op;
	cpu_pkg::fwd_e fwd_a;
	cpu_pkg::fwd_e fwd_b;
	logic [cpu_pkg::xlen-1:0] a_fwd;
	logic [cpu_pkg::xlen-1:0] b_fwd;
	logic [cpu_pkg::xlen-1:0] alu_b;
	logic [cpu_pkg::xlen-1:0] alu_res;
	logic [cpu_pkg::xlen-1:0] ex_res;
	logic [cpu_pkg::xlen-1:0] ex_addr;
	logic [cpu_pkg::xlen-1:0] br_target;
	logic [2:0] flags_q;
	logic [2:0] alu_flags;
	logic [2:0] alu_fwen;
	logic ex_shift;
	logic ex_regwrite;
	logic ex_load;
	logic cond_ok;
	logic br_taken;
	logic load_stall;
	logic flush;

	// EX/MEM
	logic mem_regwrite;
	logic mem_load;
	logic mem_store;
	logic mem_hlt;
	logic [cpu_pkg::reg_sel_w-1:0] mem_rd;
	logic [cpu_pkg::xlen-1:0] mem_res;
	logic [cpu_pkg::xlen-1:0] mem_addr;
	logic [cpu_pkg::xlen-1:0] mem_wdata;
	logic [cpu_pkg::xlen-1:0] mem_fwd;

	// MEM/WB
	logic wb_regwrite;
	logic wb_hlt;
	logic [cpu_pkg::reg_sel_w-1:0] wb_rd;
	logic [cpu_pkg::xlen-1:0] wb_data;

	logic if_en;   // PC and IF/ID may move

	// ---------------------------------------------------------------------------
	// IF
	// ---------------------------------------------------------------------------
	assign if_en = !mem_stall && !load_stall;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
			fetch_halt <= 1'b0;
			id_valid <= 1'b0;
		end else if (if_en) begin
			if (flush)
				pc <= br_target;                 // Redirect from EX
			else if (!(id_hlt || fetch_halt))
				pc <= pc + 16'd2;                // Freezes at HLT address plus 2
			fetch_halt <= fetch_halt || (id_hlt && !flush);
			id_valid <= !(flush || id_hlt || fetch_halt);
		end
	end

	always_ff @(posedge clk) begin
		if (if_en) begin
			id_ins <= imem_rdata;
			id_pc2 <= pc + 16'd2;
		end
	end

	// ---------------------------------------------------------------------------
	// ID
	// ---------------------------------------------------------------------------
	assign id_op = id_ins.r.opcode;
	assign id_hlt = id_valid && id_op == cpu_pkg::op_hlt;

	// Unused operand reads r0 so it never forwards or stalls
	always_comb begin
		id_rs_sel = '0;
		id_rt_sel = '0;
		if (id_valid) begin
			case (id_op)
				cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_xor: begin
					id_rs_sel = id_ins.r.rs;
					id_rt_sel = id_ins.r.rt;
				end
				cpu_pkg::op_sll, cpu_pkg::op_sra, cpu_pkg::op_ror, cpu_pkg::op_lw:
					id_rs_sel = id_ins.r.rs;
				cpu_pkg::op_sw: begin
					id_rs_sel = id_ins.r.rs;       // Base
					id_rt_sel = id_ins.r.rd;       // Store data
				end
				cpu_pkg::op_lhb, cpu_pkg::op_llb:
					id_rs_sel = id_ins.b.body.bt.rd;   // Other byte is kept
				default: id_rs_sel = '0;
			endcase
		end
	end

	regfile rf_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.rsel1  (id_rs_sel),
		.rsel2  (id_rt_sel),
		.wsel   (wb_rd),
		.wen    (wb_regwrite),
		.wdata  (wb_data),
		.rdata1 (id_a),
		.rdata2 (id_b)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ex_valid <= 1'b0;
		else if (!mem_stall)
			ex_valid <= id_valid && !flush && !load_stall;   // Bubble on flush or load-use
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			ex_ins <= id_ins;
			ex_pc2 <= id_pc2;
			ex_a <= id_a;
			ex_b <= id_b;
			ex_rs <= id_rs_sel;
			ex_rt <= id_rt_sel;
		end
	end

	// ---------------------------------------------------------------------------
	// EX
	// ---------------------------------------------------------------------------
	assign ex_op = ex_ins.r.opcode;
	assign ex_shift = ex_op inside {cpu_pkg::op_sll, cpu_pkg::op_sra, cpu_pkg::op_ror};
	assign ex_load = ex_valid && ex_op == cpu_pkg::op_lw;
	assign ex_regwrite = ex_valid && (ex_op inside {cpu_pkg::op_add, cpu_pkg::op_sub,
		cpu_pkg::op_xor, cpu_pkg::op_sll, cpu_pkg::op_sra, cpu_pkg::op_ror,
		cpu_pkg::op_lw, cpu_pkg::op_lhb, cpu_pkg::op_llb});

	always_comb begin
		case (fwd_a)
			cpu_pkg::fwd_mem: a_fwd = mem_fwd;
			cpu_pkg::fwd_wb:  a_fwd = wb_data;
			default:          a_fwd = ex_a;
		endcase
		case (fwd_b)
			cpu_pkg::fwd_mem: b_fwd = mem_fwd;
			cpu_pkg::fwd_wb:  b_fwd = wb_data;
			default:          b_fwd = ex_b;
		endcase
	end

	assign alu_b = ex_shift ? {{(cpu_pkg::xlen-4){1'b0}}, ex_ins.r.rt} : b_fwd;

	alu alu_inst (
		.a        (a_fwd),
		.b        (alu_b),
		.op       (ex_op),
		.result   (alu_res),
		.flags    (alu_flags),
		.flag_wen (alu_fwen)
	);

	always_comb begin
		case (ex_op)
			cpu_pkg::op_lhb: ex_res = {ex_ins.b.body.bt.imm8, a_fwd[7:0]};
			cpu_pkg::op_llb: ex_res = {a_fwd[15:8], ex_ins.b.body.bt.imm8};
			default:         ex_res = alu_res;
		endcase
	end

	// Base plus offset in words, and the branch target from pc plus 2
	assign ex_addr = a_fwd + {{(cpu_pkg::xlen-5){ex_ins.r.rt[3]}}, ex_ins.r.rt, 1'b0};
	assign br_target = ex_pc2 +
		{{(cpu_pkg::xlen-10){ex_ins.b.body.br.offset[8]}}, ex_ins.b.body.br.offset, 1'b0};

	always_comb begin
		case (ex_ins.b.body.br.cond)
			cpu_pkg::cond_ne: cond_ok = !flags_q[cpu_pkg::flag_z];
			cpu_pkg::cond_eq: cond_ok = flags_q[cpu_pkg::flag_z];
			cpu_pkg::cond_gt: cond_ok = !flags_q[cpu_pkg::flag_z] && !flags_q[cpu_pkg::flag_n];
			cpu_pkg::cond_lt: cond_ok = flags_q[cpu_pkg::flag_n];
			cpu_pkg::cond_ge: cond_ok = flags_q[cpu_pkg::flag_z] || !flags_q[cpu_pkg::flag_n];
			cpu_pkg::cond_le: cond_ok = flags_q[cpu_pkg::flag_z] || flags_q[cpu_pkg::flag_n];
			cpu_pkg::cond_ov: cond_ok = flags_q[cpu_pkg::flag_v];
			default:          cond_ok = 1'b1;
		endcase
	end

	assign br_taken = ex_valid && ex_op == cpu_pkg::op_b && cond_ok;

	// Flag register, per-bit write enables from the ALU
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			flags_q <= '0;
		else if (ex_valid && !mem_stall)
			flags_q <= (alu_fwen & alu_flags) | (~alu_fwen & flags_q);
	end

	hazard_unit hz_inst (
		.ex_rs        (ex_rs),
		.ex_rt        (ex_rt),
		.mem_rd       (mem_rd),
		.wb_rd        (wb_rd),
		.id_rs        (id_rs_sel),
		.id_rt        (id_rt_sel),
		.ex_rd        (ex_ins.r.rd),
		.mem_regwrite (mem_regwrite),
		.wb_regwrite  (wb_regwrite),
		.ex_memread   (ex_load),
		.branch_taken (br_taken),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.load_stall   (load_stall),
		.flush        (flush)
	);

	// ---------------------------------------------------------------------------
	// MEM and WB
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_regwrite <= 1'b0;
			mem_load <= 1'b0;
			mem_store <= 1'b0;
			mem_hlt <= 1'b0;
			wb_regwrite <= 1'b0;
			wb_hlt <= 1'b0;
		end else if (!mem_stall) begin
			mem_regwrite <= ex_regwrite;
			mem_load <= ex_load;
			mem_store <= ex_valid && ex_op == cpu_pkg::op_sw;
			mem_hlt <= ex_valid && ex_op == cpu_pkg::op_hlt;
			wb_regwrite <= mem_regwrite;
			wb_hlt <= wb_hlt || mem_hlt;         // Sticky until reset
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			mem_rd <= ex_ins.r.rd;
			mem_res <= ex_res;
			mem_addr <= ex_addr;
			mem_wdata <= b_fwd;
			wb_rd <= mem_rd;
			wb_data <= mem_fwd;
		end
	end

	assign mem.en = mem_load || mem_store;
	assign mem.wr = mem_store;
	assign mem.addr = mem_addr;
	assign mem.wdata = mem_wdata;

	// Load data only counts in the done cycle, otherwise everything is frozen
	assign mem_fwd = mem_load ? mem.rdata : mem_res;
	assign hlt = wb_hlt;

endmodule

`default_nettype wire

/* hw/cpu.sv */
`default_nettype none

module cpu (
	input  logic clk,
	input  logic rst_n,
	output logic [cpu_pkg::xlen-1:0] imem_addr,
	input  logic [cpu_pkg::xlen-1:0] imem_rdata,
	output logic dmem_en,
	output logic dmem_wr,
	output logic [cpu_pkg::xlen-1:0] dmem_addr,
	output logic [cpu_pkg::xlen-1:0] dmem_wdata,
	input  logic [cpu_pkg::xlen-1:0] dmem_rdata,
	input  logic dmem_valid,
	output logic hlt,
	output logic [cpu_pkg::xlen-1:0] pc_out
);

	logic mem_stall;   // Data port back-pressure

	dmem_if dmem_bus ();

	cpu_core core_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_rdata (imem_rdata),
		.pc         (pc_out),
		.mem        (dmem_bus.stage),
		.mem_stall  (mem_stall),
		.hlt        (hlt)
	);

	dmem_port port_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem        (dmem_bus.port),
		.dmem_en    (dmem_en),
		.dmem_wr    (dmem_wr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata),
		.dmem_valid (dmem_valid),
		.mem_stall  (mem_stall)
	);

	assign imem_addr = pc_out;   // Fetch straight from pc

endmodule

`default_nettype wire

/* test/cpu_checker.sv */
`default_nettype none

module cpu_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic dmem_en,
	input  logic dmem_wr,
	input  logic [15:0] dmem_addr,
	input  logic [15:0] dmem_wdata,
	input  logic dmem_valid,
	input  logic hlt,
	input  logic [15:0] pc_out,
	output int passes,
	output int fails
);
	timeunit 1ns;
	timeprecision 100ps;

	string name;
	logic [15:0] exp_addr;
	logic [15:0] exp_data;
	int exp_stores;
	logic [15:0] exp_pc;

	int store_cnt;         // Every completed store this test
	int hit_cnt;           // Stores to the expected address
	int late_stores;       // Stores after hlt
	logic [15:0] seen_data;
	logic halted;
	logic [15:0] halt_pc;

	initial begin
		passes = 0;
		fails = 0;
		halted = 1'b0;
	end

	task automatic start_test(input string n, input logic [15:0] addr,
		input logic [15:0] data, input int nstores, input logic [15:0] pc);
		name = n;
		exp_addr = addr;
		exp_data = data;
		exp_stores = nstores;
		exp_pc = pc;
		store_cnt = 0;
		hit_cnt = 0;
		late_stores = 0;
		seen_data = '0;
		halted = 1'b0;
		halt_pc = '0;
	endtask

	// ------------------------------------------------------------------------
	// Watch completed store cycles and the rise of hlt
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		if (rst_n) begin
			if (dmem_en && dmem_wr && dmem_valid) begin
				store_cnt++;
				if (halted)
					late_stores++;
				if (dmem_addr == exp_addr) begin
					hit_cnt++;
					seen_data = dmem_wdata;   // Last one to this address
				end
			end
			if (hlt && !halted) begin
				halted = 1'b1;
				halt_pc = pc_out;   // Frozen once HLT passed ID
			end
		end
	end

	task automatic finish_test();
		int errs;
		errs = 0;
		if (hit_cnt == 0) begin
			$display("%s: no store to address %h was seen", name, exp_addr);
			errs++;
		end else if (seen_data !== exp_data) begin
			$display("Fail %s: store data expected %h actual %h", name, exp_data, seen_data);
			errs++;
		end
		if (store_cnt != exp_stores) begin
			$display("Fail %s: store count expected %0d actual %0d", name, exp_stores,
				store_cnt);
			errs++;
		end
		if (!halted) begin
			$display("%s: the processor never halted", name);
			errs++;
		end else if (halt_pc !== exp_pc) begin
			$display("Fail %s: halt pc expected %h actual %h", name, exp_pc, halt_pc);
			errs++;
		end
		if (late_stores != 0) begin
			$display("%s: a store completed after the halt", name);
			errs++;
		end
		if (errs == 0) begin
			$display("%s: ok", name);
			passes++;
		end else begin
			$display("%s: %0d errors", name, errs);
			fails++;
		end
	endtask

endmodule

`default_nettype wire

/* test/tb_cpu.sv */
`default_nettype none

module tb_cpu;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int nrows = 5;
	localparam int nwords = 12;
	localparam int limit = 60 * nrows;   // Cycle budget for the whole run

	logic clk;
	logic rst_n;
	logic [15:0] imem_addr;
	logic [15:0] imem_rdata;
	logic dmem_en;
	logic dmem_wr;
	logic [15:0] dmem_addr;
	logic [15:0] dmem_wdata;
	logic [15:0] dmem_rdata;
	logic dmem_valid;
	logic hlt;
	logic [15:0] pc_out;
	int passes;
	int fails;

	logic [15:0] imem [16];
	logic [15:0] dmem [256];
	logic [31:0] rng;
	logic busy;          // Access in progress on the data port
	int wait_left;
	int cycles;

	// Test table
	string names [nrows];
	logic [15:0] words [nrows][nwords];
	logic [15:0] exp_addr [nrows];
	logic [15:0] exp_data [nrows];
	int exp_stores [nrows];
	logic [15:0] exp_pc [nrows];

	logic [15:0] v1, v2, v3, v4, v5;

	cpu cpu_inst (
		.clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
		.dmem_en(dmem_en), .dmem_wr(dmem_wr), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_valid(dmem_valid),
		.hlt(hlt), .pc_out(pc_out)
	);

	cpu_checker check_inst (
		.clk(clk), .rst_n(rst_n), .dmem_en(dmem_en), .dmem_wr(dmem_wr),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_valid(dmem_valid),
		.hlt(hlt), .pc_out(pc_out), .passes(passes), .fails(fails)
	);

	assign imem_rdata = imem[imem_addr[4:1]];   // Combinational fetch

	// ------------------------------------------------------------------------
	// Encoders and expected-value rules
	// ------------------------------------------------------------------------
	function automatic logic [15:0] reg_word(cpu_pkg::opcode_e op, logic [3:0] rd,
		logic [3:0] rs, logic [3:0] rt);
		cpu_pkg::instr_t w;
		w.r.opcode = op;
		w.r.rd = rd;
		w.r.rs = rs;
		w.r.rt = rt;   // imm4 for shifts and memory offsets
		return w;
	endfunction

	function automatic logic [15:0] branch_word(cpu_pkg::cond_e c, logic [8:0] off);
		cpu_pkg::instr_t w;
		w.b.opcode = cpu_pkg::op_b;
		w.b.body.br.cond = c;
		w.b.body.br.offset = off;
		return w;
	endfunction

	function automatic logic [15:0] byte_word(cpu_pkg::opcode_e op, logic [3:0] rd,
		logic [7:0] imm);
		cpu_pkg::instr_t w;
		w.b.opcode = op;
		w.b.body.bt.rd = rd;
		w.b.body.bt.imm8 = imm;
		return w;
	endfunction

	function automatic logic [15:0] clamp16(int s);
		if (s > 32767)
			return 16'h7fff;
		if (s < -32768)
			return 16'h8000;
		return 16'(s);
	endfunction

	function automatic logic [15:0] sat_add(logic [15:0] a, logic [15:0] b);
		return clamp16(int'($signed(a)) + int'($signed(b)));
	endfunction

	function automatic logic [15:0] sat_sub(logic [15:0] a, logic [15:0] b);
		return clamp16(int'($signed(a)) - int'($signed(b)));
	endfunction

	// Low bits shifted out come back in at the top
	function automatic logic [15:0] rotate_right(logic [15:0] v, logic [3:0] n);
		return (v >> n) | (v << (16 - n));
	endfunction

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ------------------------------------------------------------------------
	// Clock, data memory model, watchdog
	// ------------------------------------------------------------------------
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		dmem_valid = 1'b0;
		dmem_rdata = '0;
		busy = 1'b0;
		wait_left = 0;
		rng = 32'h828d_731d;
		forever begin
			@(posedge clk);
			if (dmem_en && dmem_valid) begin   // Access completes at this edge
				if (dmem_wr)
					dmem[dmem_addr[8:1]] = dmem_wdata;
				busy = 1'b0;
			end
			#1;
			dmem_valid = 1'b0;
			if (dmem_en) begin
				if (!busy) begin
					busy = 1'b1;
					rng = xorshift(rng);
					wait_left = int'(rng[1:0]);   // 0 to 3 cycles
				end
				if (wait_left == 0) begin
					dmem_valid = 1'b1;
					dmem_rdata = dmem[dmem_addr[8:1]];
				end else begin
					wait_left--;
				end
			end
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= limit) begin
				$display("timeout: the run went past %0d cycles without finishing", limit);
				$display("test failed");
				$finish;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Table and test loop
	// ------------------------------------------------------------------------
	initial begin
		rst_n = 1'b0;
		for (int r = 0; r < nrows; r++)
			for (int i = 0; i < nwords; i++)
				words[r][i] = 16'hf000;   // Pad with HLT

		// Dependent arithmetic, saturation at step 3
		names[0] = "arith_forward";
		words[0][0] = byte_word(cpu_pkg::op_llb, 4'd1, 8'h34);
		words[0][1] = byte_word(cpu_pkg::op_lhb, 4'd1, 8'h70);
		words[0][2] = byte_word(cpu_pkg::op_lhb, 4'd2, 8'h20);
		words[0][3] = reg_word(cpu_pkg::op_add, 4'd3, 4'd1, 4'd2);
		words[0][4] = reg_word(cpu_pkg::op_sub, 4'd4, 4'd3, 4'd1);
		words[0][5] = reg_word(cpu_pkg::op_xor, 4'd5, 4'd4, 4'd3);
		words[0][6] = reg_word(cpu_pkg::op_add, 4'd5, 4'd5, 4'd4);
		words[0][7] = reg_word(cpu_pkg::op_sw, 4'd5, 4'd0, 4'd4);
		v1 = 16'h7034;
		v2 = 16'h2000;
		v3 = sat_add(v1, v2);
		v4 = sat_sub(v3, v1);
		v5 = sat_add(v4 ^ v3, v4);
		exp_addr[0] = 16'h0008;
		exp_data[0] = v5;
		exp_stores[0] = 1;
		exp_pc[0] = 16'd18;

		names[1] = "shift_bytes";
		words[1][0] = byte_word(cpu_pkg::op_llb, 4'd1, 8'h81);
		words[1][1] = byte_word(cpu_pkg::op_lhb, 4'd1, 8'hc3);
		words[1][2] = reg_word(cpu_pkg::op_sra, 4'd2, 4'd1, 4'd3);
		words[1][3] = reg_word(cpu_pkg::op_sll, 4'd3, 4'd2, 4'd5);
		words[1][4] = reg_word(cpu_pkg::op_ror, 4'd4, 4'd3, 4'd7);
		words[1][5] = reg_word(cpu_pkg::op_xor, 4'd5, 4'd4, 4'd1);
		words[1][6] = reg_word(cpu_pkg::op_sw, 4'd5, 4'd0, 4'd2);
		v1 = 16'hc381;
		v2 = (v1 >> 3) | ({16{v1[15]}} << 13);   // Sign copied into the top three bits
		v3 = v2 << 5;
		v4 = rotate_right(v3, 4'd7);
		exp_addr[1] = 16'h0004;
		exp_data[1] = v4 ^ v1;
		exp_stores[1] = 1;
		exp_pc[1] = 16'd16;

		// Store, load back, use at once, store the sum below the base
		names[2] = "load_use";
		words[2][0] = byte_word(cpu_pkg::op_llb, 4'd1, 8'h55);
		words[2][1] = byte_word(cpu_pkg::op_lhb, 4'd1, 8'h12);
		words[2][2] = byte_word(cpu_pkg::op_llb, 4'd6, 8'h10);
		words[2][3] = reg_word(cpu_pkg::op_sw, 4'd1, 4'd6, 4'd1);
		words[2][4] = reg_word(cpu_pkg::op_lw, 4'd2, 4'd6, 4'd1);
		words[2][5] = reg_word(cpu_pkg::op_add, 4'd3, 4'd2, 4'd1);
		words[2][6] = reg_word(cpu_pkg::op_sw, 4'd3, 4'd6, 4'he);
		exp_addr[2] = 16'h000c;
		exp_data[2] = sat_add(16'h1255, 16'h1255);
		exp_stores[2] = 2;
		exp_pc[2] = 16'd16;

		// EQ taken over two stores, LT not taken into one
		names[3] = "branch";
		words[3][0] = byte_word(cpu_pkg::op_llb, 4'd1, 8'h05);
		words[3][1] = reg_word(cpu_pkg::op_sub, 4'd2, 4'd1, 4'd1);
		words[3][2] = branch_word(cpu_pkg::cond_eq, 9'd2);
		words[3][3] = reg_word(cpu_pkg::op_sw, 4'd1, 4'd0, 4'd1);
		words[3][4] = reg_word(cpu_pkg::op_sw, 4'd1, 4'd0, 4'd2);
		words[3][5] = reg_word(cpu_pkg::op_add, 4'd3, 4'd1, 4'd1);
		words[3][6] = branch_word(cpu_pkg::cond_lt, 9'd1);
		words[3][7] = reg_word(cpu_pkg::op_sw, 4'd3, 4'd0, 4'd3);
		exp_addr[3] = 16'h0006;
		exp_data[3] = sat_add(16'h0005, 16'h0005);
		exp_stores[3] = 1;
		exp_pc[3] = 16'd18;

		names[4] = "halt";
		words[4][0] = byte_word(cpu_pkg::op_llb, 4'd1, 8'h3c);
		words[4][1] = reg_word(cpu_pkg::op_sw, 4'd1, 4'd0, 4'd5);
		words[4][3] = reg_word(cpu_pkg::op_sw, 4'd1, 4'd0, 4'd6);   // Past the HLT
		words[4][4] = reg_word(cpu_pkg::op_sw, 4'd1, 4'd0, 4'd7);
		exp_addr[4] = 16'h000a;
		exp_data[4] = 16'h003c;
		exp_stores[4] = 1;
		exp_pc[4] = 16'd6;

		for (int r = 0; r < nrows; r++) begin
			@(posedge clk);
			#1;
			rst_n = 1'b0;
			for (int i = 0; i < 16; i++)
				imem[i] = (i < nwords) ? words[r][i] : 16'hf000;
			for (int i = 0; i < 256; i++)
				dmem[i] = (16'(i) * 16'h9e37) ^ 16'h5a5a;
			check_inst.start_test(names[r], exp_addr[r], exp_data[r], exp_stores[r],
				exp_pc[r]);
			repeat (4) @(posedge clk);
			#1;
			rst_n = 1'b1;
			while (!hlt)
				@(posedge clk);
			repeat (4) @(posedge clk);   // Room for a stray store after hlt
			check_inst.finish_test();
		end

		$display("tests run %0d, ok %0d, failed %0d", nrows, passes, fails);
		if (fails == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/cpu_pkg.sv
hw/dmem_if.sv
hw/regfile.sv
hw/alu.sv
hw/hazard_unit.sv
hw/dmem_port.sv
hw/cpu_core.sv
hw/cpu.sv
test/cpu_checker.sv
test/tb_cpu.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_cpu
FILELIST = vlog.f

SRCS = $(shell cat $(FILELIST))
BIN  = obj_dir/V$(TOP)
LOG  = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
